// ==== vlog.f ====
rtl/dma_rx_pkg.sv
rtl/ram_port_if.sv
rtl/dma_sp_ram.sv
rtl/ram_arbiter.sv
rtl/mwr_router.sv
rtl/cpld_writer.sv
rtl/bar2_drain.sv
rtl/bw_monitor.sv
rtl/dma_rx_top.sv
test/tb_dma_rx_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the dma rx testbench with verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f vlog.f \
    --top-module tb_dma_rx_top -Mdir obj_dir -o sim_tb \
    && ./obj_dir/sim_tb \
    || exit 1

// ==== test/tb_dma_rx_top.sv ====
//**********************************************************
// dma rx testbench
// directed tests for mwr routing, bar0 readback, window
// timing, bar2 drain and the stall watchdog
//**********************************************************
`default_nettype none

module tb_dma_rx_top;
    import dma_rx_pkg::*;

    logic clk = 1'b0;
    logic rst_n, i_tx_restart, i_rd_start, i_mwr_vld, i_mwr_bar;
    buf_addr_t i_mwr_addr, i_bar0_rd_addr;
    beat_t i_mwr_data, i_cpld_data;
    dwbe_t i_mwr_dwbe;
    logic i_cpld_vld, i_cpld_last, i_bar0_rd_req;
    tag_t i_cpld_tag;
    beat_idx_t i_cpld_beat;
    logic o_bar0_rd_gnt, o_bar0_rd_vld, o_bar1_wr_en, o_bar0_check_err, o_cpl_done;
    logic o_time_acc_en, o_mrd_discard, o_flush, o_bar2_rd_vld, o_bar2_check_err;
    beat_t o_bar0_rd_data, o_bar1_wr_data, o_bar2_rd_data;
    buf_addr_t o_bar1_wr_addr;
    be_t o_bar1_wr_byte_en;
    cpl_cnt_t o_cpl_count;
    cnt_t o_mrd_time;

    integer seed = 32'h3418;
    int     win_cycles;          // cycles seen with the window open
    int     rd_count;            // bar2 words returned since restart
    int     bad_idx = -1;        // word expected to raise the check error
    beat_t  sent [0:255];        // completion data in drain order
    beat_t  shadow [0:511];      // bar0 buffer model

    always #5 clk = ~clk;

    dma_rx_top uut (.*);

    //**********************************************************
    // helpers
    //**********************************************************
    task automatic check(input logic [127:0] actual, input logic [127:0] expected,
                         input string what);
        if (actual !== expected)
        begin
            $display("FAIL %0t: %s got %0h expected %0h", $time, what, actual, expected);
            $display("Done: errors found");
            $fatal(1);
        end
    endtask

    task automatic timed_out(input string what);
        $display("timeout while waiting for %s", what);
        $display("Done: errors found");
        $fatal(1);
    endtask

    // byte lanes follow their dword enable
    function automatic beat_t merge_dw(input beat_t old_d, input beat_t new_d, input dwbe_t en);
        beat_t r;
        r = old_d;
        for (int d = 0; d < 4; d++)
            if (en[d])
                r[d*32 +: 32] = new_d[d*32 +: 32];
        return r;
    endfunction

    task automatic observe;
        if (o_time_acc_en)
            win_cycles++;
        if (o_bar2_rd_vld)
        begin
            check(o_bar2_rd_data, sent[rd_count % 256], "bar2 drain data");
            check(o_bar2_check_err, rd_count == bad_idx, "bar2 check error");
            rd_count++;
        end
        else
            check(o_bar2_check_err, 0, "bar2 check error without data");
    endtask

    // sample mid-cycle, then move to the next rising edge
    task automatic cycle;
        #1 observe();
        @(posedge clk);
    endtask

    task automatic restart;
        i_tx_restart <= 1'b1;
        cycle();
        i_tx_restart <= 1'b0;
        rd_count = 0;
        bad_idx  = -1;
        cycle();
    endtask

    task automatic check_quiet(input string when);
        check({o_bar1_wr_en, o_bar0_check_err, o_bar0_rd_gnt, o_bar0_rd_vld, o_cpl_done,
               o_time_acc_en, o_mrd_discard, o_bar2_rd_vld, o_bar2_check_err}, 0, when);
    endtask

    task automatic mwr(input logic bar, input buf_addr_t a, input beat_t d, input dwbe_t en);
        i_mwr_vld  <= 1'b1;
        i_mwr_bar  <= bar;
        i_mwr_addr <= a;
        i_mwr_data <= d;
        i_mwr_dwbe <= en;
        if (!bar)
            shadow[a] = merge_dw(shadow[a], d, en);
    endtask

    task automatic cpld(input int idx, input beat_t d);
        i_cpld_vld  <= 1'b1;
        i_cpld_tag  <= tag_t'(idx / 8);
        i_cpld_beat <= beat_idx_t'(idx % 8);
        i_cpld_data <= d;
        i_cpld_last <= (idx % 8) == 7;
        sent[idx] = d;
    endtask

    //**********************************************************
    // tests
    //**********************************************************
    task automatic quiet_after_reset;
        repeat (16)
        begin
            #1 check_quiet("outputs during reset");
            cycle();
        end
        rst_n <= 1'b1;
        cycle();
        #1 check_quiet("outputs after reset");
        cycle();
    endtask

    task automatic mwr_routing;
        beat_t d;
        be_t   be;
        d = {$random(seed), $random(seed), $random(seed), $random(seed)};
        for (int i = 0; i < 16; i++)
            be[i] = (i >= 4 && i < 8) || (i >= 12);
        mwr(1'b1, 9'h1a5, d, 4'b1010);
        #1;
        check(o_bar1_wr_en, 1, "bar1 strobe");
        check(o_bar1_wr_addr, 9'h1a5, "bar1 address");
        check(o_bar1_wr_data, d, "bar1 data");
        check(o_bar1_wr_byte_en, be, "bar1 byte enables");
        cycle();
        for (int k = 0; k < 4; k++)
        begin
            mwr(1'b0, buf_addr_t'(k), (k == 3) ? beat_t'(7) : beat_t'(k), 4'hf);
            cycle();
            i_mwr_vld <= 1'b0;
            cycle();
            #1 check(o_bar0_check_err, k == 3, "bar0 sequence check");
            cycle();
        end
        restart();
    endtask

    task automatic bar0_readback;
        logic prev_wr;
        int   n;
        mwr(1'b0, 9'd40, {4{$random(seed)}}, 4'hf);
        cycle();
        mwr(1'b0, 9'd40, {4{$random(seed)}}, 4'b0110);
        cycle();
        i_mwr_vld <= 1'b0;
        cycle();
        cycle();
        prev_wr = 1'b0;
        n = 0;
        while (1)
        begin
            if (n < 6)
                mwr(1'b0, buf_addr_t'(41 + n), {4{$random(seed)}}, 4'hf);
            else
                i_mwr_vld <= 1'b0;
            if (n == 1)
            begin
                i_bar0_rd_req  <= 1'b1;    // lands behind the first write
                i_bar0_rd_addr <= 9'd40;
            end
            #1;
            if (o_bar0_rd_gnt)
                break;
            if (n > 40)
                timed_out("bar0 read grant");
            prev_wr = n < 6;
            n++;
            cycle();
        end
        check(prev_wr, 0, "bar0 read granted during a write");
        cycle();
        i_bar0_rd_req <= 1'b0;
        #1;
        check(o_bar0_rd_vld, 1, "bar0 read valid");
        check(o_bar0_rd_data, shadow[40], "bar0 read data");
        cycle();
        restart();
    endtask

    task automatic window_and_drain;
        int n;
        win_cycles = 0;
        i_rd_start <= 1'b1;
        cycle();
        i_rd_start <= 1'b0;
        #1 check(o_time_acc_en, 1, "window open");
        cycle();
        for (int i = 0; i < CPLD_TARGET * 8; i++)
        begin
            cpld(i, beat_t'(i));
            cycle();
        end
        i_cpld_vld <= 1'b0;
        n = 0;
        while (1)
        begin
            #1;
            if (!o_time_acc_en)
                break;
            if (n++ > 20)
                timed_out("window close");
            cycle();
        end
        check(o_mrd_time, win_cycles, "measured window cycles");
        check(o_cpl_count, CPLD_TARGET, "completion count");
        // flush follows the window close by a fixed delay
        n = 0;
        while (!o_flush)
        begin
            if (n > FLUSH_DELAY + 10)
                timed_out("flush pulse");
            n++;
            cycle();
            #1;
        end
        check(n, FLUSH_DELAY, "flush delay after window close");
        n = 0;
        while (rd_count < 256)
        begin
            if (n++ > 1000)
                timed_out("bar2 flush");
            cycle();
        end
        restart();
    endtask

    task automatic corrupt_beat;
        int n;
        i_rd_start <= 1'b1;
        cycle();
        i_rd_start <= 1'b0;
        for (int i = 0; i < 16; i++)
        begin
            if (i == 3)
                cpld(i, {1'b1, 31'($random(seed)), 96'(i)});
            else
                cpld(i, beat_t'(i));
            cycle();
        end
        bad_idx = 3;
        i_cpld_vld <= 1'b0;
        n = 0;
        while (rd_count < 16)
        begin
            if (n++ > 200)
                timed_out("bar2 burst");
            cycle();
        end
        restart();
    endtask

    task automatic stall_watchdog;
        int n;
        i_rd_start <= 1'b1;
        cycle();
        i_rd_start <= 1'b0;
        n = 0;
        while (1)
        begin
            #1;
            if (o_mrd_discard)
                break;
            if (n++ > 200)
                timed_out("stall flag");
            cycle();
        end
        check(n >= IDLE_LIMIT, 1, "stall flagged too early");
        cycle();
        restart();
        #1 check({o_mrd_discard, o_time_acc_en}, 0, "restart clears stall");
        cycle();
    endtask

    initial
    begin
        rst_n = 1'b0;
        i_tx_restart = 1'b0;
        i_rd_start = 1'b0;
        i_mwr_vld = 1'b0;
        i_mwr_bar = 1'b0;
        i_mwr_addr = '0;
        i_mwr_data = '0;
        i_mwr_dwbe = '0;
        i_cpld_vld = 1'b0;
        i_cpld_tag = '0;
        i_cpld_beat = '0;
        i_cpld_data = '0;
        i_cpld_last = 1'b0;
        i_bar0_rd_req = 1'b0;
        i_bar0_rd_addr = '0;
        rd_count = 0;
        win_cycles = 0;
        @(posedge clk);
        quiet_after_reset();
        mwr_routing();
        bar0_readback();
        window_and_drain();
        corrupt_beat();
        stall_watchdog();
        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== rtl/dma_rx_top.sv ====
//**********************************************************
// pcie dma receive side top
// bar0/bar2 buffers, mwr routing, completion drain and
// bandwidth measurement
//**********************************************************
`default_nettype none

module dma_rx_top (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         i_tx_restart,
    input  wire                         i_rd_start,
    // memory write beats
    input  wire                         i_mwr_vld,
    input  wire                         i_mwr_bar,
    input  wire dma_rx_pkg::buf_addr_t  i_mwr_addr,
    input  wire dma_rx_pkg::beat_t      i_mwr_data,
    input  wire dma_rx_pkg::dwbe_t      i_mwr_dwbe,
    // completion beats
    input  wire                         i_cpld_vld,
    input  wire dma_rx_pkg::tag_t       i_cpld_tag,
    input  wire dma_rx_pkg::beat_idx_t  i_cpld_beat,
    input  wire dma_rx_pkg::beat_t      i_cpld_data,
    input  wire                         i_cpld_last,
    // bar0 read port
    input  wire                         i_bar0_rd_req,
    input  wire dma_rx_pkg::buf_addr_t  i_bar0_rd_addr,
    output logic                        o_bar0_rd_gnt,
    output logic                        o_bar0_rd_vld,
    output dma_rx_pkg::beat_t           o_bar0_rd_data,
    // bar1 write strobe
    output logic                        o_bar1_wr_en,
    output dma_rx_pkg::buf_addr_t       o_bar1_wr_addr,
    output dma_rx_pkg::beat_t           o_bar1_wr_data,
    output dma_rx_pkg::be_t             o_bar1_wr_byte_en,
    // status
    output logic                        o_bar0_check_err,
    output logic                        o_cpl_done,
    output dma_rx_pkg::cpl_cnt_t        o_cpl_count,
    output logic                        o_time_acc_en,
    output dma_rx_pkg::cnt_t            o_mrd_time,
    output logic                        o_mrd_discard,
    output logic                        o_flush,
    output logic                        o_bar2_rd_vld,
    output dma_rx_pkg::beat_t           o_bar2_rd_data,
    output logic                        o_bar2_check_err
);

    ram_port_if bar0_w ();
    ram_port_if bar0_r ();
    ram_port_if bar2_w ();
    ram_port_if bar2_r ();

    // external bar0 reader
    assign bar0_r.req     = i_bar0_rd_req;
    assign bar0_r.we      = 1'b0;
    assign bar0_r.addr    = i_bar0_rd_addr;
    assign bar0_r.wdata   = '0;
    assign bar0_r.be      = '0;
    assign o_bar0_rd_gnt  = bar0_r.gnt;
    assign o_bar0_rd_vld  = bar0_r.rvld;
    assign o_bar0_rd_data = bar0_r.rdata;

    ram_arbiter u_bar0_arb (.clk(clk), .rst_n(rst_n), .port_a(bar0_w), .port_b(bar0_r));
    ram_arbiter u_bar2_arb (.clk(clk), .rst_n(rst_n), .port_a(bar2_w), .port_b(bar2_r));

    mwr_router u_mwr_router (
        .clk               (clk),
        .rst_n             (rst_n),
        .i_tx_restart      (i_tx_restart),
        .i_mwr_vld         (i_mwr_vld),
        .i_mwr_bar         (i_mwr_bar),
        .i_mwr_addr        (i_mwr_addr),
        .i_mwr_data        (i_mwr_data),
        .i_mwr_dwbe        (i_mwr_dwbe),
        .o_bar1_wr_en      (o_bar1_wr_en),
        .o_bar1_wr_addr    (o_bar1_wr_addr),
        .o_bar1_wr_data    (o_bar1_wr_data),
        .o_bar1_wr_byte_en (o_bar1_wr_byte_en),
        .o_bar0_check_err  (o_bar0_check_err),
        .bar0_w            (bar0_w)
    );

    cpld_writer u_cpld_writer (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_tx_restart (i_tx_restart),
        .i_cpld_vld   (i_cpld_vld),
        .i_cpld_tag   (i_cpld_tag),
        .i_cpld_beat  (i_cpld_beat),
        .i_cpld_data  (i_cpld_data),
        .i_cpld_last  (i_cpld_last),
        .o_cpl_done   (o_cpl_done),
        .o_cpl_count  (o_cpl_count),
        .bar2_w       (bar2_w)
    );

    bw_monitor u_bw_monitor (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_tx_restart  (i_tx_restart),
        .i_rd_start    (i_rd_start),
        .i_cpl_done    (o_cpl_done),
        .i_cpl_count   (o_cpl_count),
        .o_time_acc_en (o_time_acc_en),
        .o_mrd_time    (o_mrd_time),
        .o_mrd_discard (o_mrd_discard),
        .o_flush       (o_flush)
    );

    bar2_drain u_bar2_drain (
        .clk              (clk),
        .rst_n            (rst_n),
        .i_tx_restart     (i_tx_restart),
        .i_window         (o_time_acc_en),
        .i_flush          (o_flush),
        .i_wr_fire        (bar2_w.gnt),     // writer is always granted on request
        .o_bar2_rd_vld    (o_bar2_rd_vld),
        .o_bar2_rd_data   (o_bar2_rd_data),
        .o_bar2_check_err (o_bar2_check_err),
        .bar2_r           (bar2_r)
    );

endmodule

`default_nettype wire

// ==== rtl/bw_monitor.sv ====
//**********************************************************
// read bandwidth monitor
// measurement window, cycle count, stall watchdog and
// flush scheduling after the window closes
//**********************************************************
`default_nettype none

module bw_monitor (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        i_tx_restart,
    input  wire                        i_rd_start,
    input  wire                        i_cpl_done,
    input  wire dma_rx_pkg::cpl_cnt_t  i_cpl_count,
    output logic                       o_time_acc_en,
    output dma_rx_pkg::cnt_t           o_mrd_time,
    output logic                       o_mrd_discard,
    output logic                       o_flush
);
    import dma_rx_pkg::*;

    localparam int IDLE_W = $clog2(IDLE_LIMIT + 1);
    localparam int DLY_W  = $clog2(FLUSH_DELAY + 2);

    logic [IDLE_W-1:0] idle_cnt;
    logic [DLY_W-1:0]  dly_cnt;      // parks at FLUSH_DELAY+1

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            o_time_acc_en <= 1'b0;
            o_mrd_time    <= '0;
            o_mrd_discard <= 1'b0;
        end
        else if (i_tx_restart)
        begin
            o_time_acc_en <= 1'b0;
            o_mrd_time    <= '0;
            o_mrd_discard <= 1'b0;
        end
        else
        begin
            if (i_rd_start && (i_cpl_count == '0))
                o_time_acc_en <= 1'b1;
            else if (i_cpl_done && (i_cpl_count == cpl_cnt_t'(CPLD_TARGET)))
                o_time_acc_en <= 1'b0;
            if (o_time_acc_en && (o_mrd_time != '1))
                o_mrd_time <= o_mrd_time + 1'b1;
            if (idle_cnt == IDLE_W'(IDLE_LIMIT))
                o_mrd_discard <= 1'b1;   // sticky until restart
        end
    end

    //**********************************************************
    // stall and flush counters
    //**********************************************************
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            idle_cnt <= '0;
            dly_cnt  <= DLY_W'(FLUSH_DELAY + 1);
        end
        else if (i_tx_restart)
        begin
            idle_cnt <= '0;
            dly_cnt  <= DLY_W'(FLUSH_DELAY + 1);
        end
        else
        begin
            if (i_cpl_done || !o_time_acc_en)
                idle_cnt <= '0;
            else if (idle_cnt != IDLE_W'(IDLE_LIMIT))
                idle_cnt <= idle_cnt + 1'b1;
            if (o_time_acc_en)
                dly_cnt <= '0;
            else if (dly_cnt <= DLY_W'(FLUSH_DELAY))
                dly_cnt <= dly_cnt + 1'b1;
        end
    end

    assign o_flush = (dly_cnt == DLY_W'(FLUSH_DELAY));

endmodule

`default_nettype wire

// ==== rtl/bar2_drain.sv ====
//**********************************************************
// bar2 drain engine
// burst reads inside the window, final flush, and a
// sequence check on every returned word
//**********************************************************
`default_nettype none

module bar2_drain (
    input  wire           clk,
    input  wire           rst_n,
    input  wire           i_tx_restart,
    input  wire           i_window,
    input  wire           i_flush,
    input  wire           i_wr_fire,       // granted bar2 write
    output logic          o_bar2_rd_vld,
    output dma_rx_pkg::beat_t o_bar2_rd_data,
    output logic          o_bar2_check_err,
    ram_port_if.requester bar2_r
);
    import dma_rx_pkg::*;

    drain_state_t      state;
    logic [ADDR_W:0]   occ;            // words written but not yet read
    logic [ADDR_W:0]   rd_left;
    buf_addr_t         rd_addr;
    seq_t              exp_seq;
    logic              rd_fire;

    assign rd_fire      = bar2_r.req && bar2_r.gnt;
    assign bar2_r.req   = (state != IDLE);
    assign bar2_r.we    = 1'b0;
    assign bar2_r.addr  = rd_addr;
    assign bar2_r.wdata = '0;
    assign bar2_r.be    = '0;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            occ <= '0;
        else if (i_tx_restart)
            occ <= '0;
        else if (i_wr_fire && !rd_fire)
            occ <= occ + 1'b1;
        else if (rd_fire && !i_wr_fire)
            occ <= occ - 1'b1;
    end

    //**********************************************************
    // read fsm
    //**********************************************************
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state   <= IDLE;
            rd_left <= '0;
            rd_addr <= '0;
        end
        else if (i_tx_restart)
        begin
            state   <= IDLE;
            rd_left <= '0;
            rd_addr <= '0;
        end
        else
        begin
            if (rd_fire)
                rd_addr <= rd_addr + 1'b1;     // wraps over all tag slots
            case (state)
                IDLE:
                begin
                    if (i_flush && (occ != '0))
                    begin
                        state   <= FLUSH;
                        rd_left <= occ;
                    end
                    else if (i_window && (occ >= (ADDR_W+1)'(DRAIN_BURST)))
                    begin
                        state   <= BURST;
                        rd_left <= (ADDR_W+1)'(DRAIN_BURST);
                    end
                end
                BURST, FLUSH:
                begin
                    if (rd_fire)
                    begin
                        rd_left <= rd_left - 1'b1;
                        if (rd_left == 1)
                            state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // expected sequence runs over returned words
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            exp_seq <= '0;
        else if (i_tx_restart)
            exp_seq <= '0;
        else if (bar2_r.rvld)
            exp_seq <= exp_seq + 1'b1;
    end

    assign o_bar2_rd_vld    = bar2_r.rvld;
    assign o_bar2_rd_data   = bar2_r.rdata;
    assign o_bar2_check_err = bar2_r.rvld && (bar2_r.rdata != beat_t'(exp_seq));

    a_occ_underflow: assert property (@(posedge clk) disable iff (!rst_n)
        !((occ == '0) && rd_fire && !i_wr_fire));

endmodule

`default_nettype wire

// ==== rtl/cpld_writer.sv ====
//**********************************************************
// completion writer
// cpld beats to bar2 writes at tag/beat address,
// counts finished completions
//**********************************************************
`default_nettype none

module cpld_writer (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         i_tx_restart,
    input  wire                         i_cpld_vld,
    input  wire dma_rx_pkg::tag_t       i_cpld_tag,
    input  wire dma_rx_pkg::beat_idx_t  i_cpld_beat,
    input  wire dma_rx_pkg::beat_t      i_cpld_data,
    input  wire                         i_cpld_last,
    output logic                        o_cpl_done,
    output dma_rx_pkg::cpl_cnt_t        o_cpl_count,
    ram_port_if.requester               bar2_w
);
    import dma_rx_pkg::*;

    assign bar2_w.we = 1'b1;
    assign bar2_w.be = '1;          // completions always write full beats

    always_ff @(posedge clk)
    begin
        bar2_w.addr  <= {i_cpld_tag, i_cpld_beat};
        bar2_w.wdata <= i_cpld_data;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            bar2_w.req  <= 1'b0;
            o_cpl_done  <= 1'b0;
            o_cpl_count <= '0;
        end
        else
        begin
            bar2_w.req <= i_cpld_vld;
            o_cpl_done <= i_cpld_vld && i_cpld_last && !i_tx_restart;
            if (i_tx_restart)
                o_cpl_count <= '0;
            else if (i_cpld_vld && i_cpld_last && (o_cpl_count != '1))
                o_cpl_count <= o_cpl_count + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/mwr_router.sv ====
//**********************************************************
// memory write router
// bar1 beats out as a strobe, bar0 beats into the buffer
// with a running sequence check on the written data
//**********************************************************
`default_nettype none

module mwr_router (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        i_tx_restart,
    input  wire                        i_mwr_vld,
    input  wire                        i_mwr_bar,      // 0 bar0, 1 bar1
    input  wire dma_rx_pkg::buf_addr_t i_mwr_addr,
    input  wire dma_rx_pkg::beat_t     i_mwr_data,
    input  wire dma_rx_pkg::dwbe_t     i_mwr_dwbe,
    output logic                       o_bar1_wr_en,
    output dma_rx_pkg::buf_addr_t      o_bar1_wr_addr,
    output dma_rx_pkg::beat_t          o_bar1_wr_data,
    output dma_rx_pkg::be_t            o_bar1_wr_byte_en,
    output logic                       o_bar0_check_err,
    ram_port_if.requester              bar0_w
);
    import dma_rx_pkg::*;

    be_t  be_exp;
    seq_t seq_cnt;       // bar0 writes since restart
    logic wr_fire;

    // each dword enable covers four byte lanes
    always_comb
    begin
        for (int i = 0; i < 4; i++)
            be_exp[i*4 +: 4] = {4{i_mwr_dwbe[i]}};
    end

    //**********************************************************
    // bar1 strobe
    //**********************************************************
    always_comb
    begin
        o_bar1_wr_en      = i_mwr_vld && i_mwr_bar;
        o_bar1_wr_addr    = o_bar1_wr_en ? i_mwr_addr : '0;
        o_bar1_wr_data    = o_bar1_wr_en ? i_mwr_data : '0;
        o_bar1_wr_byte_en = o_bar1_wr_en ? be_exp : '0;
    end

    //**********************************************************
    // bar0 write request and check
    //**********************************************************
    assign bar0_w.we = 1'b1;
    assign wr_fire   = bar0_w.req && bar0_w.gnt;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            bar0_w.req <= 1'b0;
        else
            bar0_w.req <= i_mwr_vld && !i_mwr_bar;
    end

    always_ff @(posedge clk)
    begin
        bar0_w.addr  <= i_mwr_addr;
        bar0_w.wdata <= i_mwr_data;
        bar0_w.be    <= be_exp;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            seq_cnt          <= '0;
            o_bar0_check_err <= 1'b0;
        end
        else if (i_tx_restart)
        begin
            seq_cnt          <= '0;
            o_bar0_check_err <= 1'b0;
        end
        else
        begin
            if (wr_fire)
                seq_cnt <= seq_cnt + 1'b1;
            // upper bits must be zero too
            o_bar0_check_err <= wr_fire && (bar0_w.wdata != beat_t'(seq_cnt));
        end
    end

endmodule

`default_nettype wire

// ==== rtl/ram_arbiter.sv ====
//**********************************************************
// two-port write-priority arbiter on one buffer ram
// port a always wins, port b waits for a free cycle
//**********************************************************
`default_nettype none

module ram_arbiter (
    input  wire         clk,
    input  wire         rst_n,
    ram_port_if.arbiter port_a,
    ram_port_if.arbiter port_b
);
    import dma_rx_pkg::*;

    logic      ram_en;
    logic      ram_we;
    buf_addr_t ram_addr;
    beat_t     ram_wdata;
    be_t       ram_be;
    beat_t     ram_rdata;
    logic      rd_to_a, rd_to_b;     // owner of the read in flight

    assign port_a.gnt = port_a.req;
    assign port_b.gnt = port_b.req && !port_a.req;
    assign ram_en     = port_a.gnt || port_b.gnt;

    always_comb
    begin
        if (port_a.gnt)
        begin
            ram_we    = port_a.we;
            ram_addr  = port_a.addr;
            ram_wdata = port_a.wdata;
            ram_be    = port_a.be;
        end
        else
        begin
            ram_we    = port_b.we;
            ram_addr  = port_b.addr;
            ram_wdata = port_b.wdata;
            ram_be    = port_b.be;
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            rd_to_a <= 1'b0;
            rd_to_b <= 1'b0;
        end
        else
        begin
            rd_to_a <= port_a.gnt && !port_a.we;
            rd_to_b <= port_b.gnt && !port_b.we;
        end
    end

    assign port_a.rvld  = rd_to_a;
    assign port_a.rdata = ram_rdata;
    assign port_b.rvld  = rd_to_b;
    assign port_b.rdata = ram_rdata;

    dma_sp_ram u_ram (
        .clk     (clk),
        .i_en    (ram_en),
        .i_we    (ram_we),
        .i_addr  (ram_addr),
        .i_wdata (ram_wdata),
        .i_be    (ram_be),
        .o_rdata (ram_rdata)
    );

    // a waiting requester must not move its address
    a_b_addr_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (port_b.req && !port_b.gnt) |=> (port_b.addr == $past(port_b.addr)));

    // nor drop its request before the grant
    a_b_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (port_b.req && !port_b.gnt) |=> port_b.req);

endmodule

`default_nettype wire

// ==== rtl/dma_sp_ram.sv ====
//**********************************************************
// single-port buffer ram
// byte-lane writes, registered read of one cycle
//**********************************************************
`default_nettype none

module dma_sp_ram (
    input  wire                   clk,
    input  wire                   i_en,
    input  wire                   i_we,
    input  wire dma_rx_pkg::buf_addr_t i_addr,
    input  wire dma_rx_pkg::beat_t     i_wdata,
    input  wire dma_rx_pkg::be_t       i_be,
    output dma_rx_pkg::beat_t          o_rdata
);
    import dma_rx_pkg::*;

    beat_t mem [0:(2**ADDR_W)-1];

    always_ff @(posedge clk)
    begin
        if (i_en)
        begin
            if (i_we)
            begin
                for (int b = 0; b < BE_W; b++)
                begin
                    if (i_be[b])
                        mem[i_addr][b*8 +: 8] <= i_wdata[b*8 +: 8];
                end
            end
            else
            begin
                o_rdata <= mem[i_addr];
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/ram_port_if.sv ====
//**********************************************************
// one requester's access port to a shared buffer
//**********************************************************
`default_nettype none

interface ram_port_if;
    import dma_rx_pkg::*;

    logic      req;
    logic      we;
    buf_addr_t addr;
    beat_t     wdata;
    be_t       be;
    logic      gnt;
    logic      rvld;      // one cycle after a granted read
    beat_t     rdata;

    modport requester (output req, we, addr, wdata, be, input gnt, rvld, rdata);
    modport arbiter   (input req, we, addr, wdata, be, output gnt, rvld, rdata);

endinterface

`default_nettype wire

// ==== rtl/dma_rx_pkg.sv ====
//**********************************************************
// dma rx package
// buffer widths, beat types, drain fsm states and the
// constants of the read bandwidth test
//**********************************************************
`default_nettype none

package dma_rx_pkg;

    // buffer geometry
    localparam int ADDR_W = 9;
    localparam int DATA_W = 128;
    localparam int BE_W   = DATA_W / 8;
    localparam int SEQ_W  = 17;                 // check sequence in low data bits

    typedef logic [ADDR_W-1:0] buf_addr_t;      // buffer word address
    typedef logic [DATA_W-1:0] beat_t;
    typedef logic [BE_W-1:0]   be_t;
    typedef logic [3:0]        dwbe_t;
    typedef logic [5:0]        tag_t;
    typedef logic [2:0]        beat_idx_t;      // word within a tag slot of 8
    typedef logic [SEQ_W-1:0]  seq_t;
    typedef logic [31:0]       cnt_t;
    typedef logic [13:0]       cpl_cnt_t;       // saturating

    //**********************************************************
    // bandwidth test constants
    //**********************************************************
    localparam int CPLD_TARGET = 32;            // completions per measurement
    localparam int DRAIN_BURST = 16;            // words per in-window burst
    localparam int IDLE_LIMIT  = 63;            // stall watchdog
    localparam int FLUSH_DELAY = 60;            // window close to final flush

    typedef enum logic [1:0] {
        IDLE,
        BURST,
        FLUSH
    } drain_state_t;

endpackage

`default_nettype wire
